//--- fx2_bus_pkg.sv
/*
 * Bus-side definitions for the slave-FIFO master:
 * line width, master FSM states, endpoint addresses
 */
`default_nettype none

package fx2_bus_pkg;

   localparam int line_width = 16;  // One bus line

   // Burst state machine of the bus master
   typedef enum logic [3:0] {
      idle,
      think,           // Arbitration
      data_tx_sloe,    // sloe low one cycle ahead of slrd
      data_tx,         // EP2 read burst
      ctrl_tx_sloe,
      ctrl_tx,         // EP4 read burst
      data_rx_adr,     // fifoadr settles before the first write
      data_rx,         // EP6 write burst
      ctrl_rx_adr,
      ctrl_rx          // EP8 write burst
   } master_state_e;

   // Values driven on fifoadr
   typedef enum logic [1:0] {
      ep2 = 2'b00,  // Host data in
      ep4 = 2'b01,  // Host control in
      ep6 = 2'b10,  // Data back to host
      ep8 = 2'b11   // Responses back to host
   } ep_adr_e;

endpackage

`default_nettype wire

//--- frame_pkg.sv
/*
 * Frame word layout: width, flag bits, line-pair order
 */
`default_nettype none

package frame_pkg;

   localparam int frame_width = 36;

   localparam int flag_sof = 32;  // Start of frame
   localparam int flag_eof = 33;  // End of frame

   // High line first: bits 31:16 go over the bus before bits 15:0
   localparam int first_line_lsb  = 16;
   localparam int second_line_lsb = 0;

endpackage

`default_nettype wire

//--- frame_fifo.sv
/*
 * Synchronous FIFO for frame words, with a free-space count
 */
`timescale 1ns/1ps
`default_nettype none

module frame_fifo
   import frame_pkg::*;
#(
   parameter int fifo_size = 9  // log2 of the depth
) (
   input  wire                    gpif_clk,
   input  wire                    gpif_rst,
   input  wire [frame_width-1:0]  in_data,
   input  wire                    in_src_rdy,
   output logic                   in_dst_rdy,
   output logic [frame_width-1:0] out_data,
   output logic                   out_src_rdy,
   input  wire                    out_dst_rdy,
   output logic [fifo_size:0]     space        // Free entries
);

   localparam int depth = 2 ** fifo_size;

   logic [frame_width-1:0] mem [depth];
   logic [fifo_size-1:0]   wr_ptr;
   logic [fifo_size-1:0]   rd_ptr;
   logic [fifo_size:0]     count;   // Occupancy
   logic                   push;
   logic                   pop;

   assign in_dst_rdy  = count != (fifo_size + 1)'(depth);
   assign out_src_rdy = count != '0;
   assign out_data    = mem[rd_ptr];  // Head word shows without a pop
   assign space       = (fifo_size + 1)'(depth) - count;

   assign push = in_src_rdy & in_dst_rdy;
   assign pop  = out_src_rdy & out_dst_rdy;

   always_ff @(posedge gpif_clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;  // Pointers wrap on their own
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop) count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- lines_to_frame.sv
/*
 * Line packer for host-to-FPGA paths: pairs bus lines into
 * frame words and reports room for a full burst
 */
`timescale 1ns/1ps
`default_nettype none

module lines_to_frame
   import fx2_bus_pkg::*;
   import frame_pkg::*;
#(
   parameter int fifo_size = 9,
   parameter int min_space = 256  // Lines in one burst
) (
   input  wire                    gpif_clk,
   input  wire                    gpif_rst,
   input  wire [line_width-1:0]   line_data,
   input  wire                    line_valid,
   output logic                   burst_ready,
   output logic [frame_width-1:0] out_data,
   output logic                   out_src_rdy,
   input  wire                    out_dst_rdy
);

   // Words a burst can produce, the held half line included
   localparam int burst_words = (min_space + 2) / 2;

   logic [line_width-1:0]  first_line;  // High line of the pair
   logic                   half;        // First line held
   logic                   split;       // Pair straddles a gap in the lines
   logic                   sof_next;    // Next word opens a frame
   logic [frame_width-1:0] word;
   logic                   word_wr;
   logic [fifo_size:0]     space;

   assign word_wr = line_valid & half;
   assign burst_ready = space >= (fifo_size + 1)'(burst_words);

   always_comb begin
      word = '0;  // eof stays clear on this side
      word[flag_sof] = sof_next;
      word[first_line_lsb +: line_width]  = first_line;
      word[second_line_lsb +: line_width] = line_data;
   end

   always_ff @(posedge gpif_clk) begin
      if (line_valid && !half) first_line <= line_data;
   end

   //////////////////////////////////////////////////////////////////////
   // Pair and sof tracking
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         half     <= 1'b0;
         split    <= 1'b0;
         sof_next <= 1'b1;  // First word after reset
      end else if (line_valid) begin
         half <= ~half;
         if (half) begin
            sof_next <= split;  // Odd-line boundary restarts the frame
            split    <= 1'b0;
         end
      end else if (half) begin
         split <= 1'b1;  // Burst ended on an odd line
      end
   end

   frame_fifo #(.fifo_size(fifo_size)) fifo0 (
      .gpif_clk   (gpif_clk),
      .gpif_rst   (gpif_rst),
      .in_data    (word),
      .in_src_rdy (word_wr),
      .in_dst_rdy (),             // Room for a burst implies room for a word
      .out_data   (out_data),
      .out_src_rdy(out_src_rdy),
      .out_dst_rdy(out_dst_rdy),
      .space      (space)
   );

endmodule

`default_nettype wire

//--- frame_to_lines.sv
/*
 * Line unpacker for FPGA-to-host paths: buffers frame words
 * and walks each one as a high line then a low line
 */
`timescale 1ns/1ps
`default_nettype none

module frame_to_lines
   import fx2_bus_pkg::*;
   import frame_pkg::*;
#(
   parameter int fifo_size = 9
) (
   input  wire                    gpif_clk,
   input  wire                    gpif_rst,
   input  wire [frame_width-1:0]  in_data,
   input  wire                    in_src_rdy,
   output logic                   in_dst_rdy,
   output logic [line_width-1:0]  line_data,
   output logic                   line_valid,
   output logic                   line_eof,    // Low line of an eof word
   input  wire                    line_enable
);

   logic [frame_width-1:0] head;   // Word at the FIFO output
   logic                   head_valid;
   logic                   half;   // 0 high line, 1 low line
   logic                   pop;

   assign line_valid = head_valid;
   assign line_data  = half ? head[second_line_lsb +: line_width]
                            : head[first_line_lsb +: line_width];
   assign line_eof   = half & head[flag_eof];

   // Word leaves once its low line is taken
   assign pop = line_enable & head_valid & half;

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         half <= 1'b0;
      end else if (line_enable && head_valid) begin
         half <= ~half;
      end
   end

   frame_fifo #(.fifo_size(fifo_size)) fifo0 (
      .gpif_clk   (gpif_clk),
      .gpif_rst   (gpif_rst),
      .in_data    (in_data),
      .in_src_rdy (in_src_rdy),
      .in_dst_rdy (in_dst_rdy),
      .out_data   (head),
      .out_src_rdy(head_valid),
      .out_dst_rdy(pop),
      .space      ()             // Write side only needs in_dst_rdy
   );

endmodule

`default_nettype wire

//--- slave_fifo_master.sv
/*
 * Bus master for the chip's slave FIFOs: flag registers,
 * arbitration, burst FSM driving sloe, slrd, slwr, pktend, fifoadr
 */
`timescale 1ns/1ps
`default_nettype none

module slave_fifo_master
   import fx2_bus_pkg::*;
#(
   parameter int data_xfer_count = 256,  // Cap in lines, data bursts
   parameter int ctrl_xfer_count = 32    // Cap in lines, control bursts
) (
   input  wire                   gpif_clk,
   input  wire                   gpif_rst,
   input  wire [3:0]             gpif_ctl,          // Active-low chip flags
   input  wire [line_width-1:0]  gpif_d_in,
   output logic [line_width-1:0] gpif_d_out,
   output logic                  sloe,
   output logic                  slrd,
   output logic                  slwr,
   output logic                  pktend,
   output ep_adr_e               fifoadr,
   output logic [line_width-1:0] tx_line_data,      // Feeds both packers
   output logic                  tx_line_valid,
   output logic                  ctrl_line_valid,
   input  wire                   tx_burst_ready,
   input  wire                   ctrl_burst_ready,
   input  wire [line_width-1:0]  rx_line_data,
   input  wire                   rx_line_valid,
   output logic                  rx_line_enable,
   input  wire [line_width-1:0]  resp_line_data,
   input  wire                   resp_line_valid,
   input  wire                   resp_line_eof,
   output logic                  resp_line_enable
);

   localparam int max_xfer  = (data_xfer_count > ctrl_xfer_count) ?
                              data_xfer_count : ctrl_xfer_count;
   localparam int cnt_width = $clog2(max_xfer) + 1;

   //////////////////////////////////////////////////////////////////////
   // Chip flags, live and registered
   logic ep2_empty_now, ep4_empty_now, ep6_full_now, ep8_full_now;
   logic ep2_empty, ep4_empty, ep6_full, ep8_full;  // Used in think

   assign ep2_empty_now = ~gpif_ctl[0];
   assign ep4_empty_now = ~gpif_ctl[1];
   assign ep6_full_now  = ~gpif_ctl[2];
   assign ep8_full_now  = ~gpif_ctl[3];

   always_ff @(posedge gpif_clk) begin
      ep2_empty <= ep2_empty_now;
      ep4_empty <= ep4_empty_now;
      ep6_full  <= ep6_full_now;
      ep8_full  <= ep8_full_now;
   end

   master_state_e        state;
   logic [1:0]           idle_count;
   logic [cnt_width-1:0] xfer_count;   // Lines moved in this burst
   logic                 last_was_tx;  // Last data user, for alternation
   logic                 data_cap;
   logic                 ctrl_cap;
   logic                 rx_take;
   logic                 resp_take;

   assign data_cap = xfer_count == cnt_width'(data_xfer_count - 1);
   assign ctrl_cap = xfer_count == cnt_width'(ctrl_xfer_count - 1);

   // Unpackers advance while the endpoint has room
   assign rx_line_enable   = (state == data_rx) & ~ep6_full_now;
   assign resp_line_enable = (state == ctrl_rx) & ~ep8_full_now;
   assign rx_take   = rx_line_enable & rx_line_valid;
   assign resp_take = resp_line_enable & resp_line_valid;

   //////////////////////////////////////////////////////////////////////
   // Burst FSM
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         state           <= idle;
         sloe            <= 1'b1;
         slrd            <= 1'b1;
         slwr            <= 1'b1;
         pktend          <= 1'b1;
         fifoadr         <= ep2;
         tx_line_valid   <= 1'b0;
         ctrl_line_valid <= 1'b0;
         idle_count      <= '0;
         xfer_count      <= '0;
         last_was_tx     <= 1'b0;
      end else begin
         tx_line_valid   <= 1'b0;  // One-cycle pulses
         ctrl_line_valid <= 1'b0;
         case (state)
            idle: begin
               sloe       <= 1'b1;
               slrd       <= 1'b1;
               slwr       <= 1'b1;
               pktend     <= 1'b1;
               xfer_count <= '0;
               idle_count <= idle_count + 1'b1;
               if (idle_count == 2'd3) state <= think;  // Fourth idle cycle
            end
            think: begin
               idle_count <= '0;
               if (ctrl_burst_ready && !ep4_empty) begin  // Control first
                  state   <= ctrl_tx_sloe;
                  fifoadr <= ep4;
                  sloe    <= 1'b0;
               end else if (resp_line_valid && !ep8_full) begin
                  state   <= ctrl_rx_adr;
                  fifoadr <= ep8;
               end else if (tx_burst_ready && !ep2_empty && !last_was_tx) begin
                  state       <= data_tx_sloe;
                  fifoadr     <= ep2;
                  sloe        <= 1'b0;
                  last_was_tx <= 1'b1;
               end else if (rx_line_valid && !ep6_full && last_was_tx) begin
                  state       <= data_rx_adr;
                  fifoadr     <= ep6;
                  last_was_tx <= 1'b0;
               end else if (tx_burst_ready && !ep2_empty) begin  // Only one side wants the bus
                  state       <= data_tx_sloe;
                  fifoadr     <= ep2;
                  sloe        <= 1'b0;
                  last_was_tx <= 1'b1;
               end else if (rx_line_valid && !ep6_full) begin
                  state       <= data_rx_adr;
                  fifoadr     <= ep6;
                  last_was_tx <= 1'b0;
               end
            end
            data_tx_sloe: begin
               state <= data_tx;
               slrd  <= 1'b0;
            end
            ctrl_tx_sloe: begin
               state <= ctrl_tx;
               slrd  <= 1'b0;
            end
            data_tx: begin
               tx_line_valid <= ~ep2_empty_now;  // Line taken at this edge
               xfer_count    <= xfer_count + 1'b1;
               if (ep2_empty_now || data_cap) begin
                  state <= idle;
                  slrd  <= 1'b1;
               end
            end
            ctrl_tx: begin
               ctrl_line_valid <= ~ep4_empty_now;
               xfer_count      <= xfer_count + 1'b1;
               if (ep4_empty_now || ctrl_cap) begin
                  state <= idle;
                  slrd  <= 1'b1;
               end
            end
            data_rx_adr: state <= data_rx;  // fifoadr already set
            ctrl_rx_adr: state <= ctrl_rx;
            data_rx: begin
               slwr       <= ~rx_take;  // Low one cycle per line
               xfer_count <= xfer_count + 1'b1;
               if (ep6_full_now || !rx_line_valid || data_cap) state <= idle;
            end
            ctrl_rx: begin
               slwr       <= ~resp_take;
               pktend     <= ~(resp_take & resp_line_eof);  // Close packet on eof
               xfer_count <= xfer_count + 1'b1;
               if (ep8_full_now || !resp_line_valid || resp_line_eof || ctrl_cap)
                  state <= idle;
            end
            default: state <= idle;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Line registers, no reset
   always_ff @(posedge gpif_clk) begin
      tx_line_data <= gpif_d_in;
      if (state == data_rx) gpif_d_out <= rx_line_data;
      else if (state == ctrl_rx) gpif_d_out <= resp_line_data;
   end

endmodule

`default_nettype wire

//--- slave_fifo_top.sv
/*
 * Top level: bus master, two packers (tx, ctrl),
 * two unpackers (rx, resp)
 */
`timescale 1ns/1ps
`default_nettype none

module slave_fifo_top
   import fx2_bus_pkg::*;
   import frame_pkg::*;
#(
   parameter int data_xfer_count = 256,
   parameter int ctrl_xfer_count = 32,
   parameter int fifo_size       = 9
) (
   input  wire                    gpif_clk,
   input  wire                    gpif_rst,
   input  wire [line_width-1:0]   gpif_d_in,
   output logic [line_width-1:0]  gpif_d_out,   // Valid while sloe is high
   input  wire [3:0]              gpif_ctl,
   output logic                   sloe,
   output logic                   slrd,
   output logic                   slwr,
   output logic                   pktend,
   output ep_adr_e                fifoadr,
   output logic [frame_width-1:0] tx_data,
   output logic                   tx_src_rdy,
   input  wire                    tx_dst_rdy,
   input  wire [frame_width-1:0]  rx_data,
   input  wire                    rx_src_rdy,
   output logic                   rx_dst_rdy,
   output logic [frame_width-1:0] ctrl_data,
   output logic                   ctrl_src_rdy,
   input  wire                    ctrl_dst_rdy,
   input  wire [frame_width-1:0]  resp_data,
   input  wire                    resp_src_rdy,
   output logic                   resp_dst_rdy
);

   logic [line_width-1:0] rd_line;  // Read line, shared by tx and ctrl
   logic                  tx_line_valid, ctrl_line_valid;
   logic                  tx_burst_ready, ctrl_burst_ready;
   logic [line_width-1:0] rx_line_data, resp_line_data;
   logic                  rx_line_valid, resp_line_valid, resp_line_eof;
   logic                  rx_line_enable, resp_line_enable;

   slave_fifo_master #(
      .data_xfer_count(data_xfer_count),
      .ctrl_xfer_count(ctrl_xfer_count)
   ) master0 (
      .gpif_clk, .gpif_rst, .gpif_ctl, .gpif_d_in, .gpif_d_out,
      .sloe, .slrd, .slwr, .pktend, .fifoadr,
      .tx_line_data    (rd_line),
      .tx_line_valid, .ctrl_line_valid, .tx_burst_ready, .ctrl_burst_ready,
      .rx_line_data, .rx_line_valid, .rx_line_enable,
      .resp_line_data, .resp_line_valid, .resp_line_eof, .resp_line_enable
   );

   // Host to FPGA
   lines_to_frame #(.fifo_size(fifo_size), .min_space(data_xfer_count)) tx_pack0 (
      .gpif_clk, .gpif_rst,
      .line_data(rd_line), .line_valid(tx_line_valid), .burst_ready(tx_burst_ready),
      .out_data(tx_data), .out_src_rdy(tx_src_rdy), .out_dst_rdy(tx_dst_rdy)
   );

   lines_to_frame #(.fifo_size(fifo_size), .min_space(ctrl_xfer_count)) ctrl_pack0 (
      .gpif_clk, .gpif_rst,
      .line_data(rd_line), .line_valid(ctrl_line_valid), .burst_ready(ctrl_burst_ready),
      .out_data(ctrl_data), .out_src_rdy(ctrl_src_rdy), .out_dst_rdy(ctrl_dst_rdy)
   );

   // FPGA to host
   frame_to_lines #(.fifo_size(fifo_size)) rx_unpack0 (
      .gpif_clk, .gpif_rst,
      .in_data(rx_data), .in_src_rdy(rx_src_rdy), .in_dst_rdy(rx_dst_rdy),
      .line_data(rx_line_data), .line_valid(rx_line_valid),
      .line_eof(),                        // Data writes never end on eof
      .line_enable(rx_line_enable)
   );

   frame_to_lines #(.fifo_size(fifo_size)) resp_unpack0 (
      .gpif_clk, .gpif_rst,
      .in_data(resp_data), .in_src_rdy(resp_src_rdy), .in_dst_rdy(resp_dst_rdy),
      .line_data(resp_line_data), .line_valid(resp_line_valid),
      .line_eof(resp_line_eof), .line_enable(resp_line_enable)
   );

endmodule

`default_nettype wire

//--- slave_fifo_asserts.sv
/*
 * Bus strobe assertions, bound to the slave-FIFO master
 */
`timescale 1ns/1ps
`default_nettype none

module slave_fifo_asserts
   import fx2_bus_pkg::*;
(
   input wire          gpif_clk,
   input wire          gpif_rst,
   input wire          sloe,
   input wire          slrd,
   input wire          slwr,
   input wire ep_adr_e fifoadr
);

   // Read and write strobes never overlap
   strobe_excl: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
      !(!slrd && !slwr)) else $error("slrd and slwr low together");

   // Output enable leads the read strobe
   sloe_first: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
      !slrd |-> (!sloe && $past(!sloe))) else $error("slrd low without sloe low first");

   // Endpoint address held from the first write strobe on
   adr_stable: assert property (@(posedge gpif_clk) disable iff (gpif_rst)
      !slwr |-> $stable(fifoadr)) else $error("fifoadr moved during a write");

endmodule

bind slave_fifo_master slave_fifo_asserts asserts0 (
   .gpif_clk(gpif_clk), .gpif_rst(gpif_rst), .sloe(sloe),
   .slrd(slrd), .slwr(slwr), .fifoadr(fifoadr)
);

`default_nettype wire

//--- slave_fifo_tb.sv
/*
 * Testbench for slave_fifo_top: clock, reset, model of the chip's
 * four endpoint FIFOs, stim file reader, frame and line checks
 */
`timescale 1ns/1ps
`default_nettype none

module slave_fifo_tb
   import fx2_bus_pkg::*;
   import frame_pkg::*;
;
   localparam int data_cap   = 4;   // Small caps so bursts split and alternate
   localparam int ctrl_cap   = 2;
   localparam int full_level = 64;  // EP6 and EP8 report full here

   logic gpif_clk = 1'b0;
   logic gpif_rst;
   logic [line_width-1:0] gpif_d_in, gpif_d_out;
   logic [3:0] gpif_ctl;
   logic sloe, slrd, slwr, pktend;
   ep_adr_e fifoadr;
   logic [frame_width-1:0] tx_data, rx_data, ctrl_data, resp_data;
   logic tx_src_rdy, tx_dst_rdy, rx_src_rdy, rx_dst_rdy;
   logic ctrl_src_rdy, ctrl_dst_rdy, resp_src_rdy, resp_dst_rdy;

   // Chip endpoint model and expected results
   logic [line_width-1:0]  ep2_q[$], ep4_q[$];
   logic [frame_width-1:0] rx_words[$], resp_words[$], exp_tx[$], exp_ctrl[$];
   logic [line_width-1:0]  exp_rx[$], exp_resp[$];
   logic                   exp_pkt[$];
   int ep6_cnt = 0, ep8_cnt = 0, rx_acc = 0, resp_acc = 0;
   int value_errors = 0, other_errors = 0;
   int rd_count, wr_count, n_rec = 0, cycle = 0, limit;
   logic [31:0] lfsr = 32'd96480;
   logic first_burst = 1'b1, have_prev = 1'b0;
   ep_adr_e prev_data;
   // Outputs as seen at the last falling edge
   logic s_sloe, s_slrd, s_slwr, s_pkt, s_rx_hs, s_resp_hs;
   ep_adr_e s_adr;
   logic [line_width-1:0] s_dout;

   always #2 gpif_clk = ~gpif_clk;

   slave_fifo_top #(.data_xfer_count(data_cap), .ctrl_xfer_count(ctrl_cap)) dut0 (.*);

   ///////////////////////////////////////////////////////////////////////
   // Stall source and compare tasks
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;  // Galois taps
      return b;
   endfunction

   task automatic check_frame(string name, logic [frame_width-1:0] got,
                              logic [frame_width-1:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_line(string name, logic [line_width-1:0] got, logic [line_width-1:0] exp,
                             logic got_pkt, logic exp_pkt_lvl);
      if (got !== exp || got_pkt !== exp_pkt_lvl) begin
         $display("FAILED %s: got 0x%h pktend 0x%h expected 0x%h pktend 0x%h",
                  name, got, got_pkt, exp, exp_pkt_lvl);
         value_errors++;
      end
   endtask

   task automatic check_adr(string name, ep_adr_e got, ep_adr_e exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         value_errors++;
      end
   endtask

   function automatic int cap_of(ep_adr_e adr);
      return (adr == ep4 || adr == ep8) ? ctrl_cap : data_cap;
   endfunction

   // Ordering rules checked at the first line of each burst
   task automatic burst_start(ep_adr_e adr);
      logic other_pend;
      if (first_burst) check_adr("first burst fifoadr", adr, ep4);  // Control wins
      first_burst = 1'b0;
      if (adr == ep2 || adr == ep6) begin
         if (ep4_q.size() != 0 || 2 * resp_acc > ep8_cnt) begin
            $display("Data burst started while control work was still pending");
            other_errors++;
         end
         other_pend = (adr == ep2) ? (2 * rx_acc > ep6_cnt) : (ep2_q.size() != 0);
         if (have_prev && other_pend)  // Directions alternate
            check_adr("data burst fifoadr", adr, (prev_data == ep2) ? ep6 : ep2);
         prev_data = adr;
         have_prev = 1'b1;
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Stimulus, chip model and checks
   initial begin
      int fd, typ, n;
      string txt;
      logic [frame_width-1:0] val, word;
      gpif_rst = 1'b1;
      gpif_d_in = '0;
      gpif_ctl = 4'b1100;  // EP2, EP4 empty; EP6, EP8 not full
      tx_dst_rdy = 1'b1;
      ctrl_dst_rdy = 1'b1;
      rx_data = '0;
      rx_src_rdy = 1'b0;
      resp_data = '0;
      resp_src_rdy = 1'b0;
      fd = $fopen("slave_fifo_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file");
         other_errors++;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(txt, fd);
            if (n > 0 && txt.getc(0) != "#" && $sscanf(txt, "%d %h", typ, val) == 2) begin
               n_rec++;
               case (typ)
                  0: ep2_q.push_back(val[line_width-1:0]);
                  1: ep4_q.push_back(val[line_width-1:0]);
                  2: begin
                     rx_words.push_back(val);
                     exp_rx.push_back(val[31:16]);  // High line goes first
                     exp_rx.push_back(val[15:0]);
                  end
                  default: begin
                     resp_words.push_back(val);
                     exp_resp.push_back(val[31:16]);
                     exp_resp.push_back(val[15:0]);
                     exp_pkt.push_back(1'b1);
                     exp_pkt.push_back(!val[flag_eof]);  // pktend low on eof low line
                  end
               endcase
            end
         end
         $fclose(fd);
         if (n_rec == 0) begin
            $display("No records found in the stimulus file");
            other_errors++;
         end
      end
      // Lines pair up into words, sof only on the first word of each path
      for (int i = 0; i + 1 < ep2_q.size(); i += 2) begin
         word = '0;
         word[flag_sof] = (i == 0);
         word[31:0] = {ep2_q[i], ep2_q[i+1]};
         exp_tx.push_back(word);
      end
      for (int i = 0; i + 1 < ep4_q.size(); i += 2) begin
         word = '0;
         word[flag_sof] = (i == 0);
         word[31:0] = {ep4_q[i], ep4_q[i+1]};
         exp_ctrl.push_back(word);
      end
      limit = 20 * n_rec + 200;

      repeat (5) @(posedge gpif_clk);
      #1 gpif_rst = 1'b0;
      @(negedge gpif_clk);
      check_bit("sloe", sloe, 1'b1);
      check_bit("slrd", slrd, 1'b1);
      check_bit("slwr", slwr, 1'b1);
      check_bit("pktend", pktend, 1'b1);
      check_bit("tx_src_rdy", tx_src_rdy, 1'b0);
      check_bit("ctrl_src_rdy", ctrl_src_rdy, 1'b0);
      {s_sloe, s_slrd, s_slwr, s_pkt, s_rx_hs, s_resp_hs} = 6'b111100;
      s_adr = fifoadr;
      s_dout = '0;

      while (fd != 0 && (exp_tx.size() + exp_ctrl.size() + exp_rx.size() + exp_resp.size()) != 0)
      begin
         @(posedge gpif_clk);
         #1;
         if (!s_slrd) begin  // Chip hands over a line
            if (s_adr == ep2 && ep2_q.size() != 0) begin
               ep2_q.delete(0);
               rd_count++;
            end else if (s_adr == ep4 && ep4_q.size() != 0) begin
               ep4_q.delete(0);
               rd_count++;
            end
         end
         if (!s_slwr) begin  // Chip stores a line
            wr_count++;
            if (s_adr == ep6 && exp_rx.size() != 0) begin
               ep6_cnt++;
               check_line("gpif_d_out (EP6)", s_dout, exp_rx.pop_front(), s_pkt, 1'b1);
            end else if (s_adr == ep8 && exp_resp.size() != 0) begin
               ep8_cnt++;
               check_line("gpif_d_out (EP8)", s_dout, exp_resp.pop_front(), s_pkt,
                          exp_pkt.pop_front());
            end else begin
               $display("Write strobe with no line expected at that endpoint");
               other_errors++;
            end
         end
         if (!s_pkt && s_slwr) begin
            $display("pktend low without a write strobe");
            other_errors++;
         end
         if (s_rx_hs) begin
            rx_words.delete(0);
            rx_acc++;
         end
         if (s_resp_hs) begin
            resp_words.delete(0);
            resp_acc++;
         end
         rx_src_rdy = rx_words.size() != 0;
         rx_data = rx_src_rdy ? rx_words[0] : '0;
         resp_src_rdy = resp_words.size() != 0;
         resp_data = resp_src_rdy ? resp_words[0] : '0;
         tx_dst_rdy = !(lfsr_bit() & lfsr_bit());  // Stall about one cycle in four
         ctrl_dst_rdy = !(lfsr_bit() & lfsr_bit());
         gpif_ctl = {ep8_cnt < full_level, ep6_cnt < full_level,
                     ep4_q.size() != 0, ep2_q.size() != 0};
         if (fifoadr == ep2 && ep2_q.size() != 0) gpif_d_in = ep2_q[0];
         else if (fifoadr == ep4 && ep4_q.size() != 0) gpif_d_in = ep4_q[0];
         else gpif_d_in = '0;

         @(negedge gpif_clk);
         if (tx_src_rdy && tx_dst_rdy) begin
            if (exp_tx.size() == 0) begin
               $display("Extra word delivered on tx");
               other_errors++;
            end else check_frame("tx_data", tx_data, exp_tx.pop_front());
         end
         if (ctrl_src_rdy && ctrl_dst_rdy) begin
            if (exp_ctrl.size() == 0) begin
               $display("Extra word delivered on ctrl");
               other_errors++;
            end else check_frame("ctrl_data", ctrl_data, exp_ctrl.pop_front());
         end
         if (s_sloe && !sloe) begin
            rd_count = 0;
            burst_start(fifoadr);
         end
         if (!s_sloe && sloe && rd_count > cap_of(s_adr)) begin
            $display("Read burst of %0d lines is longer than its cap", rd_count);
            other_errors++;
         end
         if (s_slwr && !slwr) begin
            wr_count = 0;
            burst_start(fifoadr);
         end
         if (!s_slwr && slwr && wr_count > cap_of(s_adr)) begin
            $display("Write burst of %0d lines is longer than its cap", wr_count);
            other_errors++;
         end
         {s_sloe, s_slrd, s_slwr, s_pkt} = {sloe, slrd, slwr, pktend};
         s_adr = fifoadr;
         s_dout = gpif_d_out;
         s_rx_hs = rx_src_rdy & rx_dst_rdy;
         s_resp_hs = resp_src_rdy & resp_dst_rdy;
         cycle++;
         if (cycle >= limit) begin
            $display("Timeout after %0d cycles with results still outstanding", cycle);
            other_errors++;
            break;
         end
      end
      if (ep2_q.size() != 0 || ep4_q.size() != 0) begin
         $display("Host lines left unread in EP2 or EP4");
         other_errors++;
      end
      $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- slave_fifo_stim.txt
# type value: 0 = EP2 line, 1 = EP4 line, 2 = rx word, 3 = resp word
# lines are 16-bit hex; words are 36-bit hex with eof at bit 33
0 1a01
0 1a02
0 1a03
0 1a04
0 1a05
0 1a06
0 1a07
0 1a08
1 c0d1
1 c0d2
1 c0d3
1 c0d4
2 011112222
2 033334444
2 055556666
2 077778888
3 0a1b2c3d4
3 2e5f60718

//--- list.f
fx2_bus_pkg.sv
frame_pkg.sv
frame_fifo.sv
lines_to_frame.sv
frame_to_lines.sv
slave_fifo_master.sv
slave_fifo_top.sv
slave_fifo_asserts.sv
slave_fifo_tb.sv

//--- Makefile
# Verilator build and run for the slave-FIFO bus master

TOP = slave_fifo_tb

all: run

run:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
